// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dcache_tb
FLIST     ?= dcache_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed

SRCS := $(wildcard hw/*.sv hw/*.svh tests/*.sv)
SIM  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dcache_top.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_ifs.sv
hw/dcache_lookup.sv
hw/dcache_refill.sv
hw/dcache_load_return.sv
hw/dcache_top.sv
tests/tb_clock.sv
tests/dcache_chk.sv
tests/dcache_tb.sv

// File: hw/dcache_ifs.sv
// miss, fill write, store write and load read interfaces between the cache blocks
`timescale 1ns/1ns
`include "dcache_params.svh"

interface miss_if;
  logic                                alloc;
  logic [`DC_TAG_W+`DC_SET_W-1:0]      line;
  logic [$clog2(`DC_WAYS)-1:0]         way;
  logic                                done;
  logic                                busy;

  modport lookup (output alloc, line, way, input done, busy);
  modport refill (input alloc, line, way, output done, busy);
endinterface

interface fill_wr_if;
  logic                   wen;
  logic [`DC_INDEX_W-1:0] index;
  logic [63:0]            data;

  modport source (output wen, index, data);
  modport sink (input wen, index, data);
endinterface

interface store_wr_if;
  logic                   wen;
  logic [`DC_INDEX_W-1:0] index;
  logic [7:0]             mask;
  logic [63:0]            data;

  modport source (output wen, index, mask, data);
  modport sink (input wen, index, mask, data);
endinterface

interface load_rd_if;
  logic                   valid;
  logic [`DC_INDEX_W-1:0] index;
  dcache_pkg::dc_op_t     op;
  logic [2:0]             offset;
  logic [`DC_LSQID_W-1:0] lsqid;

  modport source (output valid, index, op, offset, lsqid);
  modport sink (input valid, index, op, offset, lsqid);
endinterface

// File: hw/dcache_load_return.sv
// data array, read register, load alignment with sign/zero extension and response register
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_load_return (
  input  logic                   clk,
  input  logic                   rst,
  fill_wr_if.sink                fill_wr,
  store_wr_if.sink               store_wr,
  load_rd_if.sink                load_rd,
  output logic                   resp_valid,
  output logic [`DC_LSQID_W-1:0] resp_lsqid,
  output logic [31:0]            resp_rdata
);
  import dcache_pkg::*;

  localparam int ENTRIES = `DC_SETS * `DC_WAYS * `DC_BEATS;

  logic [63:0]            data_mem [ENTRIES];

  // read stage
  logic                   rd_valid_r;
  logic [63:0]            rd_data_r;
  dc_op_t                 rd_op_r;
  logic [2:0]             rd_off_r;
  logic [`DC_LSQID_W-1:0] rd_lsqid_r;

  logic [31:0]            word;
  logic [31:0]            shifted;
  logic [31:0]            extended;

  // fill first, stores are byte masked
  always_ff @(posedge clk) begin
    if (fill_wr.wen) begin
      data_mem[fill_wr.index] <= fill_wr.data;
    end else if (store_wr.wen) begin
      for (int b = 0; b < 8; b++) begin
        if (store_wr.mask[b])
          data_mem[store_wr.index][b*8 +: 8] <= store_wr.data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      rd_valid_r <= 1'b0;
    else
      rd_valid_r <= load_rd.valid;
  end

  always_ff @(posedge clk) begin
    if (load_rd.valid) begin
      rd_data_r  <= data_mem[load_rd.index];
      rd_op_r    <= load_rd.op;
      rd_off_r   <= load_rd.offset;
      rd_lsqid_r <= load_rd.lsqid;
    end
  end

  always_comb begin
    word    = rd_off_r[2] ? rd_data_r[63:32] : rd_data_r[31:0];
    shifted = word >> {rd_off_r[1:0], 3'b000};
    case (rd_op_r.size)
      2'b00:   extended = rd_op_r.uns ? {24'b0, shifted[7:0]} :
                                        {{24{shifted[7]}}, shifted[7:0]};
      2'b01:   extended = rd_op_r.uns ? {16'b0, shifted[15:0]} :
                                        {{16{shifted[15]}}, shifted[15:0]};
      default: extended = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      resp_valid <= 1'b0;
    else
      resp_valid <= rd_valid_r;
  end

  always_ff @(posedge clk) begin
    if (rd_valid_r) begin
      resp_lsqid <= rd_lsqid_r;
      resp_rdata <= extended;
    end
  end

endmodule

// File: hw/dcache_lookup.sv
// request register, tag memory, tree-LRU, hit/miss decision, store alignment and L2 request
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_lookup (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  dcache_pkg::dc_op_t     op,
  input  dcache_pkg::dc_addr_u   addr,
  input  logic [`DC_LSQID_W-1:0] lsqid,
  input  logic [31:0]            wdata,
  output logic                   ready,
  output logic                   l2_req,
  output logic [31:2]            l2_addr,
  output logic                   l2_wen,
  output logic [3:0]             l2_wmask,
  output logic [31:0]            l2_wdata,
  input  logic                   l2_ready,
  miss_if.lookup                 miss,
  store_wr_if.source             store_wr,
  load_rd_if.source              load_rd
);
  import dcache_pkg::*;

  localparam int WAY_W = $clog2(`DC_WAYS);

  // registered request
  logic                   req_r;
  dc_op_t                 op_r;
  dc_addr_u               addr_r;
  logic [`DC_LSQID_W-1:0] lsqid_r;
  logic [31:0]            wdata_r;

  // tag memory
  logic [`DC_WAYS-1:0]    tag_valid [`DC_SETS];
  logic [`DC_TAG_W-1:0]   tag_mem [`DC_SETS][`DC_WAYS];
  dc_lru_t                lru_mem [`DC_SETS];

  logic [`DC_WAYS-1:0]    hits;
  logic                   hit;
  logic [WAY_W-1:0]       hit_way;
  logic [WAY_W-1:0]       victim;
  logic [WAY_W-1:0]       miss_way_r;
  dc_lru_t                lru;
  logic                   l2_accept;
  logic                   store_hit;
  logic [3:0]             wmask;
  logic [31:0]            wdata_aligned;

  // point the tree away from the way just used
  function automatic dc_lru_t next_lru(input logic [WAY_W-1:0] way, input dc_lru_t cur);
    dc_lru_t nxt;
    nxt[2] = ~way[1];
    nxt[1] = way[1] ? ~way[0] : cur[1];
    nxt[0] = way[1] ? cur[0] : ~way[0];
    return nxt;
  endfunction

  always_comb begin
    lru = lru_mem[addr_r.f.set_idx];
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      hits[w] = tag_valid[addr_r.f.set_idx][w] &&
                (tag_mem[addr_r.f.set_idx][w] == addr_r.f.tag);
      if (hits[w])
        hit_way = WAY_W'(w);
    end
    hit = |hits;
  end

  // lowest invalid way wins, else the LRU leaf
  always_comb begin
    victim = lru[2] ? {1'b1, lru[1]} : {1'b0, lru[0]};
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!tag_valid[addr_r.f.set_idx][w])
        victim = WAY_W'(w);
    end
  end

  // stores always go out, loads only on a miss, nothing while refilling
  assign l2_req    = req_r && !miss.busy && (op_r.write || !hit);
  assign l2_accept = l2_req && l2_ready;
  assign store_hit = l2_accept && op_r.write && hit;
  assign ready     = !rst && (!req_r || (op_r.write ? l2_accept : hit));

  assign l2_addr  = op_r.write ? addr_r[31:2] : {addr_r.l.line, 4'b0000};
  assign l2_wen   = op_r.write;
  assign l2_wmask = wmask;
  assign l2_wdata = wdata_aligned;

  assign miss.alloc = l2_accept && !op_r.write;
  assign miss.line  = addr_r.l.line;
  assign miss.way   = victim;

  // store data replicated across the word
  always_comb begin
    case (op_r.size)
      2'b00: begin
        wmask = 4'b0001 << addr_r.f.boff;
        wdata_aligned = {4{wdata_r[7:0]}};
      end
      2'b01: begin
        wmask = addr_r.f.boff[1] ? 4'b1100 : 4'b0011;
        wdata_aligned = {2{wdata_r[15:0]}};
      end
      default: begin
        wmask = 4'b1111;
        wdata_aligned = wdata_r;
      end
    endcase
  end

  assign store_wr.wen   = store_hit;
  assign store_wr.index = {addr_r.f.set_idx, hit_way, addr_r.f.beat};
  assign store_wr.mask  = addr_r.f.word ? {wmask, 4'b0000} : {4'b0000, wmask};
  assign store_wr.data  = {2{wdata_aligned}};

  assign load_rd.valid  = req_r && !op_r.write && hit;
  assign load_rd.index  = {addr_r.f.set_idx, hit_way, addr_r.f.beat};
  assign load_rd.op     = op_r;
  assign load_rd.offset = {addr_r.f.word, addr_r.f.boff};
  assign load_rd.lsqid  = lsqid_r;

  always_ff @(posedge clk) begin
    if (rst)
      req_r <= 1'b0;
    else if (ready)
      req_r <= req;
  end

  always_ff @(posedge clk) begin
    if (ready && req) begin
      op_r    <= op;
      addr_r  <= addr;
      lsqid_r <= lsqid;
      wdata_r <= wdata;
    end
  end

  // victim invalid from alloc until its line is complete
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        tag_valid[s] <= '0;
        lru_mem[s]   <= '0;
      end
    end else begin
      if (miss.alloc) begin
        tag_valid[addr_r.f.set_idx][victim] <= 1'b0;
        lru_mem[addr_r.f.set_idx] <= next_lru(victim, lru);
      end else if (load_rd.valid || store_hit) begin
        lru_mem[addr_r.f.set_idx] <= next_lru(hit_way, lru);
      end
      if (miss.done)
        tag_valid[addr_r.f.set_idx][miss_way_r] <= 1'b1;
    end
  end

  // the missing request stays in addr_r until done
  always_ff @(posedge clk) begin
    if (miss.alloc)
      miss_way_r <= victim;
    if (miss.done)
      tag_mem[addr_r.f.set_idx][miss_way_r] <= addr_r.f.tag;
  end

endmodule

// File: hw/dcache_params.svh
// geometry and field width macros for the data cache
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// 32 KB, 4 ways, 64 B lines
`define DC_WAYS     4
`define DC_SETS     128
`define DC_SET_W    7
`define DC_TAG_W    19

// a line is eight 64-bit beats
`define DC_BEATS    8
`define DC_BEAT_W   3

// data array index is {set, way, beat}
`define DC_INDEX_W  12

// load/store queue id
`define DC_LSQID_W  4

`endif

// File: hw/dcache_pkg.sv
// address union, operation encoding and tree-LRU state type for the data cache
`include "dcache_params.svh"

package dcache_pkg;

  // one address word, seen as lookup fields or as line address plus offset
  typedef union packed {
    struct packed {
      logic [`DC_TAG_W-1:0]  tag;
      logic [`DC_SET_W-1:0]  set_idx;
      logic [`DC_BEAT_W-1:0] beat;
      logic                  word;
      logic [1:0]            boff;
    } f;
    struct packed {
      logic [`DC_TAG_W+`DC_SET_W-1:0] line;
      logic [`DC_BEAT_W+2:0]          offset;
    } l;
  } dc_addr_u;

  // size: 00 byte, 01 half, 1x word
  typedef struct packed {
    logic       uns;
    logic [1:0] size;
    logic       write;
  } dc_op_t;

  // bit 2 picks the half, bits 1 and 0 pick the way inside each half
  typedef logic [2:0] dc_lru_t;

endpackage

// File: hw/dcache_refill.sv
// miss register and eight-entry refill buffer draining into the data array
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_refill (
  input  logic        clk,
  input  logic        rst,
  input  logic        l2_resp_valid,
  input  logic [63:0] l2_resp_rdata,
  miss_if.refill      miss,
  fill_wr_if.source   fill_wr
);
  import dcache_pkg::*;

  localparam int WAY_W = $clog2(`DC_WAYS);

  // miss register
  logic                           busy_r;
  logic [`DC_TAG_W+`DC_SET_W-1:0] line_r;
  logic [WAY_W-1:0]               way_r;

  // refill buffer, extra pointer bit tells full from empty
  logic [63:0]                    beat_buf [`DC_BEATS];
  logic [`DC_BEAT_W:0]            head;
  logic [`DC_BEAT_W:0]            tail;
  logic                           fill_wen;
  dc_addr_u                       line_addr;

  always_comb begin
    line_addr.l.line   = line_r;
    line_addr.l.offset = '0;
  end

  assign fill_wen      = head != tail;
  assign fill_wr.wen   = fill_wen;
  assign fill_wr.index = {line_addr.f.set_idx, way_r, head[`DC_BEAT_W-1:0]};
  assign fill_wr.data  = beat_buf[head[`DC_BEAT_W-1:0]];

  // last beat of the line leaves the buffer
  assign miss.done = fill_wen && (&head[`DC_BEAT_W-1:0]);
  assign miss.busy = busy_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_r <= 1'b0;
      head   <= '0;
      tail   <= '0;
    end else begin
      if (miss.alloc)
        busy_r <= 1'b1;
      else if (miss.done)
        busy_r <= 1'b0;
      if (l2_resp_valid)
        tail <= tail + 1'b1;
      if (fill_wen)
        head <= head + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (miss.alloc) begin
      line_r <= miss.line;
      way_r  <= miss.way;
    end
    if (l2_resp_valid)
      beat_buf[tail[`DC_BEAT_W-1:0]] <= l2_resp_rdata;
  end

endmodule

// File: hw/dcache_top.sv
// data cache top level wiring lookup, refill and load return to plain LSQ and L2 ports
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_top (
  input  logic                   clk,
  input  logic                   rst,
  // load/store queue side
  input  logic                   req,
  input  logic [3:0]             op,
  input  logic [31:0]            addr,
  input  logic [`DC_LSQID_W-1:0] lsqid,
  input  logic [31:0]            wdata,
  output logic                   ready,
  output logic                   resp_valid,
  output logic [`DC_LSQID_W-1:0] resp_lsqid,
  output logic [31:0]            resp_rdata,
  // L2 side
  output logic                   l2_req,
  output logic [31:2]            l2_addr,
  output logic                   l2_wen,
  output logic [3:0]             l2_wmask,
  output logic [31:0]            l2_wdata,
  input  logic                   l2_ready,
  input  logic                   l2_resp_valid,
  input  logic [63:0]            l2_resp_rdata
);

  miss_if     miss ();
  fill_wr_if  fill_wr ();
  store_wr_if store_wr ();
  load_rd_if  load_rd ();

  dcache_lookup lookup_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .op       (op),
    .addr     (addr),
    .lsqid    (lsqid),
    .wdata    (wdata),
    .ready    (ready),
    .l2_req   (l2_req),
    .l2_addr  (l2_addr),
    .l2_wen   (l2_wen),
    .l2_wmask (l2_wmask),
    .l2_wdata (l2_wdata),
    .l2_ready (l2_ready),
    .miss     (miss.lookup),
    .store_wr (store_wr.source),
    .load_rd  (load_rd.source)
  );

  dcache_refill refill_i (
    .clk           (clk),
    .rst           (rst),
    .l2_resp_valid (l2_resp_valid),
    .l2_resp_rdata (l2_resp_rdata),
    .miss          (miss.refill),
    .fill_wr       (fill_wr.source)
  );

  dcache_load_return load_return_i (
    .clk        (clk),
    .rst        (rst),
    .fill_wr    (fill_wr.sink),
    .store_wr   (store_wr.sink),
    .load_rd    (load_rd.sink),
    .resp_valid (resp_valid),
    .resp_lsqid (resp_lsqid),
    .resp_rdata (resp_rdata)
  );

endmodule

// File: tests/dcache_chk.sv
// concurrent assertions on the data cache top-level LSQ and L2 ports
`timescale 1ns/1ns

module dcache_chk (
  input logic        clk,
  input logic        rst,
  input logic        resp_valid,
  input logic        l2_req,
  input logic [31:2] l2_addr,
  input logic        l2_wen,
  input logic [3:0]  l2_wmask,
  input logic [31:0] l2_wdata,
  input logic        l2_ready,
  input logic        l2_resp_valid
);

  logic       rst_d = 1'b0;
  logic       miss_open = 1'b0;
  logic [3:0] beats = 4'd0;

  // a line read is open from its acceptance until the eighth beat
  always @(posedge clk) begin
    rst_d <= rst;
    if (rst) begin
      miss_open <= 1'b0;
      beats     <= 4'd0;
    end else if (l2_req && l2_ready && !l2_wen) begin
      miss_open <= 1'b1;
      beats     <= 4'd0;
    end else if (l2_resp_valid) begin
      if (beats == 4'd7)
        miss_open <= 1'b0;
      beats <= beats + 4'd1;
    end
  end

  // response register cleared from the first reset edge on
  assert property (@(posedge clk) rst && rst_d |-> !resp_valid)
    else $error("resp_valid high during reset");

  assert property (@(posedge clk) disable iff (rst)
    l2_req && !l2_ready |=> l2_req && $stable(l2_addr) && $stable(l2_wen) &&
                            $stable(l2_wmask) && $stable(l2_wdata))
    else $error("L2 request changed before l2_ready");

  assert property (@(posedge clk) disable iff (rst) miss_open |-> !l2_req)
    else $error("L2 request raised while a line read is outstanding");

endmodule

// File: tests/dcache_tb.sv
// data cache testbench with L2 memory model, LFSR, compare task, directed tests and timeout
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tb;

  // op encoding {unsigned, size, write}
  localparam logic [3:0] OP_LB  = 4'b0000;
  localparam logic [3:0] OP_LH  = 4'b0010;
  localparam logic [3:0] OP_LW  = 4'b0100;
  localparam logic [3:0] OP_LBU = 4'b1000;
  localparam logic [3:0] OP_LHU = 4'b1010;
  localparam logic [3:0] OP_SB  = 4'b0001;
  localparam logic [3:0] OP_SH  = 4'b0011;
  localparam logic [3:0] OP_SW  = 4'b0101;

  // worst miss: 3 delay, 8 beats with 8 gaps, drain, replay and 3 hit cycles
  localparam int RESET_CYCLES = 16;
  localparam int WORST_OP     = 30;
  localparam int NUM_OPS      = 45;
  localparam int TIMEOUT      = 20 * (RESET_CYCLES + NUM_OPS * WORST_OP);

  logic                   clk;
  logic                   rst;
  logic                   req;
  logic [3:0]             op;
  logic [31:0]            addr;
  logic [`DC_LSQID_W-1:0] lsqid;
  logic [31:0]            wdata;
  logic                   ready;
  logic                   resp_valid;
  logic [`DC_LSQID_W-1:0] resp_lsqid;
  logic [31:0]            resp_rdata;
  logic                   l2_req;
  logic [31:2]            l2_addr;
  logic                   l2_wen;
  logic [3:0]             l2_wmask;
  logic [31:0]            l2_wdata;
  logic                   l2_ready = 1'b0;
  logic                   l2_resp_valid = 1'b0;
  logic [63:0]            l2_resp_rdata = '0;

  // L2 model state
  logic [31:0]            l2_mem [logic [29:0]];
  logic [15:0]            lfsr_state = 16'd66;
  int                     l2_reads = 0;
  int                     l2_writes = 0;
  logic [29:0]            last_rd_addr = '0;
  logic [29:0]            last_wr_addr = '0;
  logic [3:0]             last_wr_mask = '0;
  logic [31:0]            last_wr_data = '0;
  logic [29:0]            fill_base;
  int                     beats_left = 0;
  logic                   gap_done = 1'b0;
  logic                   delay_armed = 1'b0;
  logic [3:0]             delay_left;
  logic [3:0]             rnd;

  int                     cycles = 0;
  int                     checks = 0;
  int                     errors = 0;

  tb_clock #(.PERIOD(20)) clock_i (.clk(clk));

  dcache_top dcache_top_i (.*);

  bind dcache_top dcache_chk dcache_chk_i (
    .clk           (clk),
    .rst           (rst),
    .resp_valid    (resp_valid),
    .l2_req        (l2_req),
    .l2_addr       (l2_addr),
    .l2_wen        (l2_wen),
    .l2_wmask      (l2_wmask),
    .l2_wdata      (l2_wdata),
    .l2_ready      (l2_ready),
    .l2_resp_valid (l2_resp_valid)
  );

  // 16-bit Galois LFSR, one step per bit taken
  function automatic logic [3:0] lfsr_bits(input int n);
    logic [3:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[2:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  // untouched memory holds a word built from its whole address
  function automatic logic [31:0] mem_word(input logic [29:0] wa);
    if (l2_mem.exists(wa))
      return l2_mem[wa];
    return {wa[15:0], wa[29:14]} ^ {2'b00, wa} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [63:0] line_beat(input logic [29:0] base, input int b);
    return {mem_word(base + 30'(2 * b + 1)), mem_word(base + 30'(2 * b))};
  endfunction

  task automatic merge_word(input logic [29:0] wa, input logic [3:0] m, input logic [31:0] d);
    logic [31:0] w;
    w = mem_word(wa);
    for (int b = 0; b < 4; b++) begin
      if (m[b])
        w[b*8 +: 8] = d[b*8 +: 8];
    end
    l2_mem[wa] = w;
  endtask

  // expected load result by size, offset and signedness
  function automatic logic [31:0] load_expect(input logic [31:0] w, input logic [1:0] off,
                                              input logic [3:0] o);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[{off, 3'b000} +: 8];
    h = off[1] ? w[31:16] : w[15:0];
    if (o[2:1] == 2'b00)
      return o[3] ? {24'd0, b} : {{24{b[7]}}, b};
    if (o[2:1] == 2'b01)
      return o[3] ? {16'd0, h} : {{16{h[15]}}, h};
    return w;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // L2 side: random ready delay, line beats with single-cycle gaps
  always @(posedge clk) begin
    if (rst) begin
      l2_ready      <= 1'b0;
      l2_resp_valid <= 1'b0;
      beats_left    = 0;
      delay_armed   = 1'b0;
    end else begin
      if (beats_left > 0) begin
        rnd = lfsr_bits(1);
        if (!gap_done && rnd != 4'd0) begin
          l2_resp_valid <= 1'b0;
          gap_done = 1'b1;
        end else begin
          l2_resp_valid <= 1'b1;
          l2_resp_rdata <= line_beat(fill_base, 8 - beats_left);
          beats_left--;
          gap_done = 1'b0;
        end
      end else begin
        l2_resp_valid <= 1'b0;
      end
      if (l2_req && l2_ready) begin
        l2_ready <= 1'b0;
        if (l2_wen) begin
          merge_word(l2_addr, l2_wmask, l2_wdata);
          l2_writes    <= l2_writes + 1;
          last_wr_addr <= l2_addr;
          last_wr_mask <= l2_wmask;
          last_wr_data <= l2_wdata;
        end else begin
          fill_base = l2_addr;
          beats_left = 8;
          gap_done = 1'b0;
          l2_reads     <= l2_reads + 1;
          last_rd_addr <= l2_addr;
        end
      end else if (l2_req) begin
        if (!delay_armed) begin
          delay_left = lfsr_bits(2);
          delay_armed = 1'b1;
        end
        if (delay_left == 4'd0) begin
          l2_ready <= 1'b1;
          delay_armed = 1'b0;
        end else begin
          delay_left = delay_left - 4'd1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Error: run did not finish within %0d cycles", TIMEOUT);
      $display("Verification failed");
      $finish;
    end
  end

  // holds the request until the edge where ready is seen
  task automatic send_req(input logic [3:0] o, input logic [31:0] a,
                          input logic [`DC_LSQID_W-1:0] id, input logic [31:0] d,
                          output int at);
    req   <= 1'b1;
    op    <= o;
    addr  <= a;
    lsqid <= id;
    wdata <= d;
    do @(posedge clk); while (!ready);
    req <= 1'b0;
    at = cycles;
  endtask

  task automatic load_check(input logic [3:0] o, input logic [31:0] a,
                            input logic [`DC_LSQID_W-1:0] id, input logic want_read,
                            output int lat);
    int reads_before;
    int at;
    reads_before = l2_reads;
    send_req(o, a, id, 32'd0, at);
    do @(posedge clk); while (!resp_valid);
    lat = cycles - at;
    compare("resp_rdata", resp_rdata, load_expect(mem_word(a[31:2]), a[1:0], o));
    compare("resp_lsqid", 32'(resp_lsqid), 32'(id));
    compare("l2 read count", 32'(l2_reads - reads_before), 32'(want_read));
    if (want_read)
      compare("l2_addr", {2'b00, last_rd_addr}, {2'b00, a[31:6], 4'd0});
  endtask

  task automatic store_check(input logic [3:0] o, input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] exp_mask, input logic [31:0] exp_data);
    int reads_before;
    int writes_before;
    int at;
    reads_before = l2_reads;
    writes_before = l2_writes;
    send_req(o, a, '0, d, at);
    // wait for the L2 handshake, then one edge for the model to record it
    do @(posedge clk); while (!(l2_req && l2_ready));
    @(posedge clk);
    compare("l2 write count", 32'(l2_writes - writes_before), 32'd1);
    compare("l2 read count", 32'(l2_reads - reads_before), 32'd0);
    compare("l2_addr", {2'b00, last_wr_addr}, {2'b00, a[31:2]});
    compare("l2_wmask", {28'd0, last_wr_mask}, {28'd0, exp_mask});
    compare("l2_wdata", last_wr_data, exp_data);
  endtask

  task automatic test_load_miss();
    int lat;
    load_check(OP_LW, 32'h0001_2348, 4'd3, 1'b1, lat);
  endtask

  task automatic test_load_hit();
    int lat;
    load_check(OP_LHU, 32'h0001_2356, 4'd11, 1'b0, lat);
    compare("load hit latency", 32'(lat), 32'd3);
  endtask

  task automatic test_load_ext();
    logic [31:0] base;
    int          lat;
    base = 32'h0004_0a10;
    // sign bits set and clear in alternating bytes and halves
    l2_mem[base[31:2]] = 32'h80ff_7f01;
    l2_mem[base[31:2] + 30'd1] = 32'h7f01_80ff;
    for (int k = 0; k < 8; k++) begin
      load_check(OP_LB, base + 32'(k), 4'(k), k == 0, lat);
      load_check(OP_LBU, base + 32'(k), 4'(k), 1'b0, lat);
    end
    for (int k = 0; k < 4; k++) begin
      load_check(OP_LH, base + 32'(2 * k), 4'(k), 1'b0, lat);
      load_check(OP_LHU, base + 32'(2 * k), 4'(k), 1'b0, lat);
    end
    for (int k = 0; k < 2; k++)
      load_check(OP_LW, base + 32'(4 * k), 4'(k), 1'b0, lat);
  endtask

  task automatic test_store();
    logic [31:0] a;
    logic [31:0] c;
    logic [31:0] orig_hi;
    int          lat;
    a = 32'h0001_2360;
    c = 32'h0007_8008;
    orig_hi = mem_word(a[31:2] + 30'd1);
    // line of a is resident since the miss test
    store_check(OP_SW, a, 32'hdead_beef, 4'b1111, 32'hdead_beef);
    store_check(OP_SB, a + 32'd1, 32'h1234_565a, 4'b0010, 32'h5a5a_5a5a);
    store_check(OP_SH, a + 32'd6, 32'h0000_c3d2, 4'b1100, 32'hc3d2_c3d2);
    load_check(OP_LW, a, 4'd8, 1'b0, lat);
    compare("resp_rdata after store hit", resp_rdata, 32'hdead_5aef);
    load_check(OP_LW, a + 32'd4, 4'd9, 1'b0, lat);
    compare("resp_rdata after store hit", resp_rdata, {16'hc3d2, orig_hi[15:0]});
    // store miss allocates nothing
    store_check(OP_SW, c, 32'h1357_9bdf, 4'b1111, 32'h1357_9bdf);
    load_check(OP_LW, c, 4'd10, 1'b1, lat);
    compare("resp_rdata after store miss", resp_rdata, 32'h1357_9bdf);
  endtask

  function automatic logic [31:0] set7_line(input int k);
    return ((32'(k) + 32'd32) << 13) | 32'h0000_01cc;
  endfunction

  task automatic test_replace();
    int lat;
    for (int k = 0; k < 4; k++)
      load_check(OP_LW, set7_line(k), 4'(k), 1'b1, lat);
    load_check(OP_LW, set7_line(0), 4'd4, 1'b0, lat);
    // way 0 used last, tree names the upper half and then way 2
    load_check(OP_LW, set7_line(4), 4'd5, 1'b1, lat);
    load_check(OP_LW, set7_line(0), 4'd6, 1'b0, lat);
    load_check(OP_LW, set7_line(1), 4'd7, 1'b0, lat);
    load_check(OP_LW, set7_line(3), 4'd8, 1'b0, lat);
    load_check(OP_LW, set7_line(2), 4'd9, 1'b1, lat);
  endtask

  initial begin
    rst   <= 1'b1;
    req   <= 1'b0;
    op    <= '0;
    addr  <= '0;
    lsqid <= '0;
    wdata <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_load_miss();
    test_load_hit();
    test_load_ext();
    test_store();
    test_replace();
    repeat (4) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: tests/tb_clock.sv
// free-running testbench clock generator
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule
